// ==== list.f ====
+incdir+include
src/write_engine_pkg.sv
src/write_data_fifo.sv
src/write_stream_fsm.sv
src/request_counter.sv
src/write_command_builder.sv
src/write_engine_top.sv
sim/tb_write_engine.sv

// ==== include/tb_write_engine_util.svh ====
////////////////////
// write engine testbench helpers
// galois LFSR, line generator, cycle budget and the
// reference queues shared by driver, monitor and responder
////////////////////

`ifndef TB_WRITE_ENGINE_UTIL_SVH
`define TB_WRITE_ENGINE_UTIL_SVH

logic [31:0] lfsr_state = 32'hb8d8_db6a;

// lines made for the next job, not yet pushed
write_engine_pkg::data_line_t stage_q [$];
// lines pushed but not yet seen as commands
write_engine_pkg::data_line_t pushed_q [$];
// responder entries, due cycle and element count
int          resp_due_q [$];
logic [31:0] resp_size_q [$];

// one LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] value;
	int          i;
	value = '0;
	for (i = 0; i < n; i++) begin
		value = {value[30:0], lfsr_state[0]};
		if (lfsr_state[0])
			lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
		else
			lfsr_state = lfsr_state >> 1;
	end
	return value;
endfunction

// 1 to 16 elements, random payload
function automatic write_engine_pkg::data_line_t make_line(input logic [31:0] offset);
	write_engine_pkg::data_line_t line;
	int                           w;
	line.offset    = offset;
	line.real_size = rand_bits(4) + 32'd1;
	for (w = 0; w < write_engine_pkg::DATA_W / 32; w++)
		line.data[w*32 +: 32] = rand_bits(32);
	return line;
endfunction

function automatic int cycle_budget(input int lines);
	return lines * 10 + 50;
endfunction

`endif

// ==== sim/tb_write_engine.sv ====
////////////////////
// write engine testbench
// random jobs and lines, delayed responder, reference
// queue checks on every command, FIFO levels and job ends
////////////////////

`timescale 1ns/1ps

module tb_write_engine;

	localparam int FIFO_DEPTH         = write_engine_pkg::FIFO_DEPTH_DEF;
	localparam int FIFO_HEADROOM      = write_engine_pkg::FIFO_HEADROOM_DEF;
	localparam int MAX_ROUND_REQUESTS = write_engine_pkg::MAX_ROUND_REQUESTS_DEF;
	localparam int ENGINE_ID          = write_engine_pkg::ENGINE_ID_DEF;
	localparam int JOB_COUNT          = 6;
	localparam int LINE_W             = $bits(write_engine_pkg::data_line_t);

	logic                                clock;
	logic                                rstn;
	logic                                job_valid;
	write_engine_pkg::job_t              job;
	logic                                data_valid;
	write_engine_pkg::data_line_t        data_in;
	logic                                resp_valid;
	write_engine_pkg::write_resp_t       resp;
	logic                                cmd_alfull;
	logic                                cmd_valid;
	write_engine_pkg::write_cmd_t        cmd;
	logic                                wdata_valid;
	write_engine_pkg::data_line_t        wdata;
	logic                                job_done;
	logic                                busy;
	logic [write_engine_pkg::SIZE_W-1:0] done_count;
	write_engine_pkg::fifo_status_t      data_status;

	// reference state written by the driver after the edge and read by the monitor on it
	write_engine_pkg::job_t                  cur_job;
	write_engine_pkg::data_line_t            exp_line;
	logic [write_engine_pkg::ADDR_W-1:0]     exp_addr;
	logic [write_engine_pkg::CMD_SIZE_W-1:0] exp_bytes;
	logic [31:0] exp_done = '0;
	int          cycle_count = 0;
	int          timeout_limit = 0;
	int          outstanding = 0;
	int          last_due = 0;
	int          job_cmds = 0;
	int          job_line_count = 0;
	bit          job_active = 1'b0;
	bit          alfull_mode = 1'b0;
	bit          alfull_q = 1'b0;
	int          job_lines [JOB_COUNT] = '{5, 20, FIFO_DEPTH, 11, 1, 17};
	int          k;

	`include "tb_write_engine_util.svh"

	write_engine_top #(
		.FIFO_DEPTH        (FIFO_DEPTH),
		.FIFO_HEADROOM     (FIFO_HEADROOM),
		.MAX_ROUND_REQUESTS(MAX_ROUND_REQUESTS),
		.ENGINE_ID         (ENGINE_ID)
	) write_engine_top_i (.*);

	always #10 clock = ~clock;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [LINE_W-1:0] got,
			input logic [LINE_W-1:0] expected);
		$display("Mismatch %s got %0h expected %0h", name, got, expected);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// advance one cycle and drive inputs 1 ns after the edge
	task automatic step();
		@(posedge clock);
		#1;
		cmd_alfull = alfull_mode ? (rand_bits(2) == 32'd0) : 1'b0;
	endtask

	task automatic push_lines(input bit check_level);
		int pushed;
		pushed = 0;
		while (stage_q.size() > 0) begin
			if (!data_status.full) begin
				data_in    = stage_q.pop_front();
				data_valid = 1'b1;
				pushed_q.push_back(data_in);
				pushed++;
			end
			step();
			data_valid = 1'b0;
			if (check_level && pushed == FIFO_DEPTH - FIFO_HEADROOM - 1)
				assert (!data_status.alfull) else fail_run("almost-full raised too early");
			if (check_level && pushed == FIFO_DEPTH - FIFO_HEADROOM)
				assert (data_status.alfull && !data_status.full)
					else fail_run("almost-full not raised at its level");
			if (check_level && pushed == FIFO_DEPTH)
				assert (data_status.full) else fail_run("full not raised with a full FIFO");
		end
	endtask

	task automatic run_job(input int n_lines, input write_engine_pkg::write_opcode_e op,
			input bit throttle, input bit prefill, input bit intrude);
		write_engine_pkg::job_t       new_job;
		write_engine_pkg::data_line_t line;
		logic [31:0]                  offset;
		logic [31:0]                  addr_hi;
		logic [31:0]                  addr_lo;
		int                           i;
		offset             = rand_bits(10) * 64;
		new_job.total_size = '0;
		for (i = 0; i < n_lines; i++) begin
			line = make_line(offset);
			stage_q.push_back(line);
			new_job.total_size += line.real_size;
			offset += 64 * (1 + rand_bits(1));
		end
		addr_hi           = rand_bits(32);
		addr_lo           = rand_bits(26);
		new_job.base_addr = {addr_hi, addr_lo[25:0], 6'b0};
		new_job.opcode    = op;
		alfull_mode       = throttle;
		// lines wait in the FIFO while the engine is idle
		if (prefill)
			push_lines(1'b1);
		while (busy)
			step();
		cur_job        = new_job;
		job_line_count = n_lines;
		job_cmds       = 0;
		exp_done       += new_job.total_size;
		job_active     = 1'b1;
		job_valid      = 1'b1;
		job            = new_job;
		step();
		job_valid = 1'b0;
		if (intrude) begin
			assert (busy) else fail_run("engine not busy after taking a job");
			job_valid        = 1'b1;
			job.base_addr    = ~new_job.base_addr;
			job.total_size   = 32'd7;
			step();
			job_valid = 1'b0;
		end
		if (!prefill)
			push_lines(1'b0);
		while (job_active)
			step();
		alfull_mode = 1'b0;
		step();
		assert (!busy && data_status.empty)
			else fail_run("engine not idle and drained after a job");
	endtask

	////////////////////
	// monitor
	////////////////////

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= timeout_limit)
			fail_run($sformatf("timeout after %0d cycles", cycle_count));
		if (alfull_q)
			assert (!cmd_valid)
				else fail_run("command issued right after cmd_alfull was high");
		alfull_q = cmd_alfull;
		assert (wdata_valid == cmd_valid)
			else report_mismatch("wdata_valid", wdata_valid, cmd_valid);
		if (cmd_valid) begin
			assert (job_active && pushed_q.size() > 0)
				else fail_run("command with no running job or no pushed line");
			exp_line  = pushed_q.pop_front();
			exp_addr  = cur_job.base_addr + write_engine_pkg::ADDR_W'(exp_line.offset);
			exp_bytes = write_engine_pkg::CMD_SIZE_W'(exp_line.real_size *
			            write_engine_pkg::ELEM_BYTES);
			assert (cmd.address == exp_addr)
				else report_mismatch("cmd.address", cmd.address, exp_addr);
			assert (cmd.byte_size == exp_bytes)
				else report_mismatch("cmd.byte_size", cmd.byte_size, exp_bytes);
			assert (cmd.real_size == exp_line.real_size)
				else report_mismatch("cmd.real_size", cmd.real_size, exp_line.real_size);
			assert (cmd.engine_id == ENGINE_ID)
				else report_mismatch("cmd.engine_id", cmd.engine_id, ENGINE_ID);
			assert (cmd.opcode == cur_job.opcode)
				else report_mismatch("cmd.opcode", cmd.opcode, cur_job.opcode);
			assert (wdata == exp_line) else report_mismatch("wdata", wdata, exp_line);
			job_cmds++;
			outstanding++;
			// one command served at a time, each delay starts after the previous answer
			last_due = (last_due > cycle_count) ? last_due : cycle_count;
			last_due += int'(rand_bits(3));
			resp_due_q.push_back(last_due);
			resp_size_q.push_back(exp_line.real_size);
		end
		if (resp_valid)
			outstanding--;
		assert (outstanding <= MAX_ROUND_REQUESTS)
			else fail_run($sformatf("%0d commands awaiting a response", outstanding));
		if (job_done) begin
			assert (job_active) else fail_run("job_done with no running job");
			assert (outstanding == 0 && job_cmds == job_line_count)
				else fail_run("job_done before every command was answered");
			assert (done_count == exp_done)
				else report_mismatch("done_count", done_count, exp_done);
			job_active = 1'b0;
		end
	end

	// answers commands in order once their delay has passed
	always @(posedge clock) begin
		#1;
		if (resp_due_q.size() > 0 && resp_due_q[0] <= cycle_count) begin
			resp_valid     = 1'b1;
			resp.real_size = resp_size_q.pop_front();
			resp_due_q.delete(0);
		end else begin
			resp_valid = 1'b0;
		end
	end

	initial begin
		clock      = 1'b0;
		rstn       = 1'b0;
		job_valid  = 1'b0;
		job        = '0;
		data_valid = 1'b0;
		data_in    = '0;
		resp_valid = 1'b0;
		resp       = '0;
		cmd_alfull = 1'b0;
		for (k = 0; k < JOB_COUNT; k++)
			timeout_limit += cycle_budget(job_lines[k]);
		timeout_limit *= 4;
		repeat (5) @(posedge clock);
		#1;
		rstn = 1'b1;
		repeat (3) step();
		assert (!cmd_valid && !wdata_valid && !job_done && !busy && done_count == '0)
			else fail_run("outputs not cleared by reset");
		// job 1 spans three rounds and job 2 fills the FIFO first
		// job 3 sees a second job_valid while busy
		for (k = 0; k < JOB_COUNT; k++)
			run_job(job_lines[k],
				(k % 2 == 1) ? write_engine_pkg::write_ms : write_engine_pkg::write_na,
				k == 1 || k >= 4, k == 2, k == 3);
		repeat (10) step();
		assert (done_count == exp_done)
			else report_mismatch("done_count", done_count, exp_done);
		assert (pushed_q.size() == 0 && outstanding == 0 && data_status.empty)
			else fail_run("lines or responses left over at the end");
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== src/write_engine_top.sv ====
////////////////////
// write engine top level
// data FIFO, stream FSM, request counter and command builder
////////////////////

`timescale 1ns/1ps

module write_engine_top #(
	parameter int FIFO_DEPTH         = write_engine_pkg::FIFO_DEPTH_DEF,
	parameter int FIFO_HEADROOM      = write_engine_pkg::FIFO_HEADROOM_DEF,
	parameter int MAX_ROUND_REQUESTS = write_engine_pkg::MAX_ROUND_REQUESTS_DEF,
	parameter int ENGINE_ID          = write_engine_pkg::ENGINE_ID_DEF
) (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                job_valid,
	input  write_engine_pkg::job_t              job,
	input  logic                                data_valid,
	input  write_engine_pkg::data_line_t        data_in,
	input  logic                                resp_valid,
	input  write_engine_pkg::write_resp_t       resp,
	input  logic                                cmd_alfull,
	output logic                                cmd_valid,
	output write_engine_pkg::write_cmd_t        cmd,
	output logic                                wdata_valid,
	output write_engine_pkg::data_line_t        wdata,
	output logic                                job_done,
	output logic                                busy,
	output logic [write_engine_pkg::SIZE_W-1:0] done_count,
	output write_engine_pkg::fifo_status_t      data_status
);

	write_engine_pkg::data_line_t head_line;
	logic                         pop;
	logic                         issue;
	logic                         remaining_zero;
	logic                         job_load;
	logic                         send_enable;
	logic                         round_clear;
	logic                         budget_full;
	logic                         round_settled;

	write_data_fifo #(
		.FIFO_DEPTH   (FIFO_DEPTH),
		.FIFO_HEADROOM(FIFO_HEADROOM)
	) write_data_fifo_i (
		.clock    (clock),
		.rstn     (rstn),
		.push     (data_valid),
		.push_line(data_in),
		.pop      (pop),
		.head_line(head_line),
		.status   (data_status)
	);

	write_stream_fsm write_stream_fsm_i (
		.clock         (clock),
		.rstn          (rstn),
		.job_valid     (job_valid),
		.budget_full   (budget_full),
		.round_settled (round_settled),
		.remaining_zero(remaining_zero),
		.job_load      (job_load),
		.send_enable   (send_enable),
		.round_clear   (round_clear),
		.job_done      (job_done),
		.busy          (busy)
	);

	request_counter #(
		.MAX_ROUND_REQUESTS(MAX_ROUND_REQUESTS)
	) request_counter_i (
		.clock        (clock),
		.rstn         (rstn),
		.issue        (issue),
		.round_clear  (round_clear),
		.resp_valid   (resp_valid),
		.resp         (resp),
		.budget_full  (budget_full),
		.round_settled(round_settled),
		.done_count   (done_count)
	);

	write_command_builder #(
		.ENGINE_ID(ENGINE_ID)
	) write_command_builder_i (
		.clock         (clock),
		.rstn          (rstn),
		.job_load      (job_load),
		.job           (job),
		.send_enable   (send_enable),
		.head_line     (head_line),
		.fifo_status   (data_status),
		.cmd_alfull    (cmd_alfull),
		.pop           (pop),
		.issue         (issue),
		.remaining_zero(remaining_zero),
		.cmd_valid     (cmd_valid),
		.cmd           (cmd),
		.wdata_valid   (wdata_valid),
		.wdata         (wdata)
	);

endmodule

// ==== src/write_command_builder.sv ====
////////////////////
// write command builder
// holds the job, pops data lines and registers one write
// command with its data line per popped line
////////////////////

`timescale 1ns/1ps

module write_command_builder #(
	parameter int ENGINE_ID = write_engine_pkg::ENGINE_ID_DEF
) (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           job_load,
	input  write_engine_pkg::job_t         job,
	input  logic                           send_enable,
	input  write_engine_pkg::data_line_t   head_line,
	input  write_engine_pkg::fifo_status_t fifo_status,
	input  logic                           cmd_alfull,
	output logic                           pop,
	output logic                           issue,
	output logic                           remaining_zero,
	output logic                           cmd_valid,
	output write_engine_pkg::write_cmd_t   cmd,
	output logic                           wdata_valid,
	output write_engine_pkg::data_line_t   wdata
);

	write_engine_pkg::job_t                job_q;
	logic [write_engine_pkg::SIZE_W-1:0]   remaining;

	////////////////////
	// issue decision
	////////////////////

	// hold lines in the FIFO while the command buffer is nearly full
	assign issue = send_enable && !fifo_status.empty && !cmd_alfull;
	assign pop   = issue;

	// looks ahead at the line going out this cycle
	assign remaining_zero = issue ? (remaining <= head_line.real_size)
	                              : (remaining == '0);

	////////////////////
	// job hold
	////////////////////

	always_ff @(posedge clock) begin
		if (job_load)
			job_q <= job;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			remaining <= '0;
		else if (job_load)
			remaining <= job.total_size;
		else if (issue)
			remaining <= remaining - head_line.real_size;
	end

	////////////////////
	// command and data outputs
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_valid   <= 1'b0;
			wdata_valid <= 1'b0;
		end else begin
			cmd_valid   <= issue;
			wdata_valid <= issue;
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			cmd.address   <= job_q.base_addr +
			                 write_engine_pkg::ADDR_W'(head_line.offset);
			cmd.byte_size <= write_engine_pkg::CMD_SIZE_W'(head_line.real_size *
			                 write_engine_pkg::ELEM_BYTES);
			cmd.real_size <= head_line.real_size;
			cmd.engine_id <= write_engine_pkg::ID_W'(ENGINE_ID);
			cmd.opcode    <= job_q.opcode;
			wdata         <= head_line;
		end
	end

endmodule

// ==== src/request_counter.sv ====
////////////////////
// request counter
// sent and acknowledged commands per round, round budget,
// and the running count of written elements
////////////////////

`timescale 1ns/1ps

module request_counter #(
	parameter int MAX_ROUND_REQUESTS = write_engine_pkg::MAX_ROUND_REQUESTS_DEF
) (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic                              issue,
	input  logic                              round_clear,
	input  logic                              resp_valid,
	input  write_engine_pkg::write_resp_t     resp,
	output logic                              budget_full,
	output logic                              round_settled,
	output logic [write_engine_pkg::SIZE_W-1:0] done_count
);

	localparam int CNT_W = $clog2(MAX_ROUND_REQUESTS + 1);

	logic                          resp_q_valid;
	write_engine_pkg::write_resp_t resp_q;
	logic [CNT_W-1:0]              sent_count;
	logic [CNT_W-1:0]              resp_count;
	logic [CNT_W-1:0]              sent_next;
	logic [CNT_W-1:0]              resp_next;

	// response input stage
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			resp_q_valid <= 1'b0;
		else
			resp_q_valid <= resp_valid;
	end

	always_ff @(posedge clock) begin
		resp_q <= resp;
	end

	always_comb begin
		sent_next = sent_count + CNT_W'(issue);
		resp_next = resp_count + CNT_W'(resp_q_valid);
		if (round_clear) begin
			sent_next = '0;
			resp_next = '0;
		end
	end

	// full already in the cycle of the last allowed issue
	assign budget_full = (sent_count >= CNT_W'(MAX_ROUND_REQUESTS)) ||
	                     (issue && (sent_count == CNT_W'(MAX_ROUND_REQUESTS - 1)));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sent_count    <= '0;
			resp_count    <= '0;
			round_settled <= 1'b0;
			done_count    <= '0;
		end else begin
			sent_count    <= sent_next;
			resp_count    <= resp_next;
			// compare the new counts, not the old ones
			round_settled <= (sent_next == resp_next) && !round_clear;
			if (resp_q_valid)
				done_count <= done_count + resp_q.real_size;
		end
	end

endmodule

// ==== src/write_stream_fsm.sv ====
////////////////////
// write stream FSM
// takes a job, then runs request rounds until no elements
// are left, waiting for all responses after every round
////////////////////

`timescale 1ns/1ps

module write_stream_fsm (
	input  logic clock,
	input  logic rstn,
	input  logic job_valid,
	input  logic budget_full,
	input  logic round_settled,
	input  logic remaining_zero,
	output logic job_load,
	output logic send_enable,
	output logic round_clear,
	output logic job_done,
	output logic busy
);

	write_engine_pkg::stream_state_e state;
	write_engine_pkg::stream_state_e next_state;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			state <= write_engine_pkg::stream_reset;
		else
			state <= next_state;
	end

	////////////////////
	// next state
	////////////////////

	always_comb begin
		next_state = state;
		case (state)
			write_engine_pkg::stream_reset: begin
				next_state = write_engine_pkg::stream_idle;
			end
			write_engine_pkg::stream_idle: begin
				if (job_valid)
					next_state = write_engine_pkg::stream_set;
			end
			write_engine_pkg::stream_set: begin
				next_state = write_engine_pkg::stream_start;
			end
			write_engine_pkg::stream_start: begin
				next_state = write_engine_pkg::stream_req;
			end
			// both inputs look ahead at this cycle's issue,
			// so the round never overshoots
			write_engine_pkg::stream_req: begin
				if (budget_full || remaining_zero)
					next_state = write_engine_pkg::stream_pending;
			end
			write_engine_pkg::stream_pending: begin
				if (round_settled)
					next_state = write_engine_pkg::stream_done;
			end
			write_engine_pkg::stream_done: begin
				if (remaining_zero)
					next_state = write_engine_pkg::stream_idle;
				else
					next_state = write_engine_pkg::stream_start;
			end
			default: begin
				next_state = write_engine_pkg::stream_reset;
			end
		endcase
	end

	////////////////////
	// outputs
	////////////////////

	// single cycle strobes
	assign job_load    = (state == write_engine_pkg::stream_idle) && job_valid;
	assign round_clear = (state == write_engine_pkg::stream_start);
	assign job_done    = (state == write_engine_pkg::stream_done) && remaining_zero;

	// registered from next state, so they line up with the state itself
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			send_enable <= 1'b0;
			busy        <= 1'b0;
		end else begin
			send_enable <= (next_state == write_engine_pkg::stream_req);
			busy        <= (next_state != write_engine_pkg::stream_idle) &&
			               (next_state != write_engine_pkg::stream_reset);
		end
	end

endmodule

// ==== src/write_data_fifo.sv ====
////////////////////
// write data FIFO
// circular buffer of data lines, head readable combinationally,
// reports full, almost-full and empty
////////////////////

`timescale 1ns/1ps

module write_data_fifo #(
	parameter int FIFO_DEPTH    = write_engine_pkg::FIFO_DEPTH_DEF,
	parameter int FIFO_HEADROOM = write_engine_pkg::FIFO_HEADROOM_DEF
) (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          push,
	input  write_engine_pkg::data_line_t  push_line,
	input  logic                          pop,
	output write_engine_pkg::data_line_t  head_line,
	output write_engine_pkg::fifo_status_t status
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	write_engine_pkg::data_line_t mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// pointers wrap at the depth, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign do_push = push && !status.full;
	assign do_pop  = pop && !status.empty;

	assign head_line     = mem[rd_ptr];
	assign status.full   = (count == CNT_W'(FIFO_DEPTH));
	assign status.alfull = (count >= CNT_W'(FIFO_DEPTH - FIFO_HEADROOM));
	assign status.empty  = (count == '0);

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= push_line;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== src/write_engine_pkg.sv ====
////////////////////
// write engine shared definitions
// widths, job/line/command structs, state and opcode enums,
// and the default values of the top level parameters
////////////////////

package write_engine_pkg;

	////////////////////
	// widths
	////////////////////

	localparam int ADDR_W     = 64;
	localparam int DATA_W     = 512;
	localparam int SIZE_W     = 32;
	localparam int OFFSET_W   = 32;
	localparam int ELEM_BYTES = 4;
	localparam int ID_W       = 4;
	localparam int CMD_SIZE_W = 12;

	// parameter defaults, overridden from the top level
	localparam int FIFO_DEPTH_DEF         = 16;
	localparam int FIFO_HEADROOM_DEF      = 4;
	localparam int MAX_ROUND_REQUESTS_DEF = 8;
	localparam int ENGINE_ID_DEF          = 3;

	////////////////////
	// enums
	////////////////////

	typedef enum logic {
		write_na = 1'b0,
		write_ms = 1'b1
	} write_opcode_e;

	typedef enum logic [2:0] {
		stream_reset   = 3'd0,
		stream_idle    = 3'd1,
		stream_set     = 3'd2,
		stream_start   = 3'd3,
		stream_req     = 3'd4,
		stream_pending = 3'd5,
		stream_done    = 3'd6
	} stream_state_e;

	////////////////////
	// structs
	////////////////////

	// job descriptor, total_size counts elements
	typedef struct packed {
		logic [ADDR_W-1:0] base_addr;
		logic [SIZE_W-1:0] total_size;
		write_opcode_e     opcode;
	} job_t;

	// one data line plus its place in the array
	typedef struct packed {
		logic [OFFSET_W-1:0] offset;
		logic [SIZE_W-1:0]   real_size;
		logic [DATA_W-1:0]   data;
	} data_line_t;

	typedef struct packed {
		logic [ADDR_W-1:0]     address;
		logic [CMD_SIZE_W-1:0] byte_size;
		logic [SIZE_W-1:0]     real_size;
		logic [ID_W-1:0]       engine_id;
		write_opcode_e         opcode;
	} write_cmd_t;

	typedef struct packed {
		logic [SIZE_W-1:0] real_size;
	} write_resp_t;

	typedef struct packed {
		logic full;
		logic alfull;
		logic empty;
	} fifo_status_t;

endpackage
